// ==== logic/wbreg_pkg.sv ====
// --------------------
// Register bank constants
// --------------------

`default_nettype none

package wbreg_pkg;

   // Width of the Wishbone data word in bits.
   parameter int DATA_W = 32;

   // One select bit per 8-bit lane of the data word.
   parameter int SEL_W = DATA_W / 8;

   // Word address width, which leaves room for up to 16 register slots.
   parameter int ADDR_W = 4;

   // Pattern on DAT_O in every cycle without an acknowledge.
   // A master that samples data at the wrong time sees this obvious value.
   parameter logic [DATA_W-1:0] IDLE_DATA = 32'hd0d0_d0d0;

   // Reset value of register 0.
   // Register i resets to this base plus i, so each slot is recognizable.
   parameter logic [DATA_W-1:0] INIT_BASE = 32'hdead_babe;

endpackage

`default_nettype wire

// ==== logic/wb_addr_decode.sv ====
// --------------------
// Word address decoder
// --------------------

`timescale 1ns/100ps
`default_nettype none

module wb_addr_decode #(
   parameter int N_REGS = 4
) (
   input  wire logic                        CLK_I,
   input  wire logic                        rst_n,
   input  wire logic [wbreg_pkg::ADDR_W-1:0] ADR_I,
   input  wire logic                        STB_I,
   input  wire logic                        ack,
   output logic      [N_REGS-1:0]           reg_stb,
   output logic                             ERR_O
);

   // High while the master strobes an address with no register behind it.
   logic unmapped;
   // Set once the error for the current strobe has been given.
   logic err_pend;
   // Error to be raised at the coming edge.
   logic err_next;

   // One strobe per register, and only for the addressed one.
   // Unmapped addresses never reach any register.
   always_comb begin
      reg_stb = '0;
      for (int i = 0; i < N_REGS; i++) begin
         if (STB_I && int'(ADR_I) == i) begin
            reg_stb[i] = 1'b1;
         end
      end
   end

   assign unmapped = STB_I && (int'(ADR_I) >= N_REGS);

   // The error is held back while an acknowledge is on the bus.
   // Then ACK_O and ERR_O can never be high in the same cycle.
   assign err_next = unmapped && !err_pend && !ack;

   // ERR_O is a registered pulse in cycle 1 of the strobe.
   // The pending bit lasts until the master drops STB_I, so a held strobe
   // gets only one error.
   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         ERR_O    <= 1'b0;
         err_pend <= 1'b0;
      end else begin
         ERR_O    <= err_next;
         err_pend <= unmapped && (err_pend || err_next);
      end
   end

endmodule

`default_nettype wire

// ==== logic/wb_latency_reg.sv ====
// --------------------
// Wishbone latency register
// --------------------

`timescale 1ns/100ps
`default_nettype none

module wb_latency_reg #(
   parameter logic [wbreg_pkg::DATA_W-1:0] INIT_VALUE    = wbreg_pkg::INIT_BASE,
   parameter int                           WRITE_LATENCY = 1,
   parameter int                           READ_LATENCY  = 2
) (
   input  wire logic                        CLK_I,
   input  wire logic                        rst_n,
   input  wire logic                        stb,
   input  wire logic                        WE_I,
   input  wire logic [wbreg_pkg::SEL_W-1:0]  SEL_I,
   input  wire logic [wbreg_pkg::DATA_W-1:0] DAT_I,
   output logic                             ack,
   output logic      [wbreg_pkg::DATA_W-1:0] reg_q
);

   // Index 0 is the write path and index 1 the read path.
   logic [1:0] path_stb;
   logic [1:0] path_ack;

   // The stored word.
   // Each 8-bit lane is written only when its select bit is set.
   // Lanes with a clear select bit keep their old contents.
   always_ff @(posedge CLK_I) begin
      if (!rst_n) begin
         reg_q <= INIT_VALUE;
      end else if (stb && WE_I) begin
         for (int b = 0; b < wbreg_pkg::SEL_W; b++) begin
            if (SEL_I[b]) begin
               reg_q[8*b +: 8] <= DAT_I[8*b +: 8];
            end
         end
      end
   end

   // Split the strobe by direction.
   // Each direction then gets its own acknowledge delay.
   assign path_stb[0] = stb && WE_I;
   assign path_stb[1] = stb && !WE_I;

   // One delay line per direction.
   // Both use the same code and differ only in their latency.
   for (genvar k = 0; k < 2; k++) begin : g_path
      localparam int LAT = (k == 0) ? WRITE_LATENCY : READ_LATENCY;

      if (LAT == 0) begin : g_direct
         // Zero latency: the acknowledge follows the strobe in the same cycle.
         assign path_ack[k] = path_stb[k];
      end else begin : g_delay
         // The top bit is loaded at the edge that ends cycle 0.
         // It then walks down one bit per cycle and reaches bit 0 in cycle LAT.
         logic [LAT-1:0] dly;

         // The line loads only while it is empty.
         // A strobe held through its own acknowledge does not start a second
         // pulse, so each access gets exactly one acknowledge.
         always_ff @(posedge CLK_I) begin
            if (!rst_n) begin
               dly <= '0;
            end else begin
               dly <= dly >> 1;
               if (dly == '0 && path_stb[k]) begin
                  dly[LAT-1] <= 1'b1;
               end
            end
         end

         assign path_ack[k] = dly[0];
      end
   end

   // Only one direction is active per access.
   // So at most one path acknowledges in any cycle.
   assign ack = |path_ack;

endmodule

`default_nettype wire

// ==== logic/wb_read_mux.sv ====
// --------------------
// Read data collector
// --------------------

`timescale 1ns/100ps
`default_nettype none

module wb_read_mux #(
   parameter int N_REGS = 4
) (
   input  wire logic [N_REGS-1:0]            ack_vec,
   input  wire logic [wbreg_pkg::DATA_W-1:0] reg_q_vec [N_REGS],
   output logic                              ACK_O,
   output logic      [wbreg_pkg::DATA_W-1:0] DAT_O
);

   // Any register acknowledge is the bus acknowledge.
   assign ACK_O = |ack_vec;

   // Only the strobed register can acknowledge.
   // So at most one bit of ack_vec is high, and the loop picks its word.
   // With no acknowledge the bus shows the idle pattern.
   // Write acknowledges also show the stored word, which holds the new value.
   always_comb begin
      DAT_O = wbreg_pkg::IDLE_DATA;
      for (int i = 0; i < N_REGS; i++) begin
         if (ack_vec[i]) begin
            DAT_O = reg_q_vec[i];
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/wb_reg_bank.sv ====
// --------------------
// Wishbone register bank
// --------------------

`timescale 1ns/100ps
`default_nettype none

module wb_reg_bank #(
   parameter int N_REGS        = 4,
   parameter int WRITE_LATENCY = 1,
   parameter int READ_LATENCY  = 2
) (
   input  wire logic                        CLK_I,
   input  wire logic                        rst_n,
   input  wire logic [wbreg_pkg::ADDR_W-1:0] ADR_I,
   input  wire logic [wbreg_pkg::DATA_W-1:0] DAT_I,
   input  wire logic [wbreg_pkg::SEL_W-1:0]  SEL_I,
   input  wire logic                        WE_I,
   input  wire logic                        STB_I,
   output logic      [wbreg_pkg::DATA_W-1:0] DAT_O,
   output logic                             ACK_O,
   output logic                             ERR_O
);

   // Strobe for each register, from the decoder.
   logic [N_REGS-1:0]            reg_stb;
   // Acknowledge from each register, to the collector.
   logic [N_REGS-1:0]            reg_ack;
   // Stored word of each register, to the collector.
   logic [wbreg_pkg::DATA_W-1:0] reg_q [N_REGS];

   // The decoder also watches the merged acknowledge.
   // That keeps an error from sharing a cycle with an acknowledge.
   wb_addr_decode #(
      .N_REGS (N_REGS)
   ) i_addr_decode (
      .CLK_I   (CLK_I),
      .rst_n   (rst_n),
      .ADR_I   (ADR_I),
      .STB_I   (STB_I),
      .ack     (ACK_O),
      .reg_stb (reg_stb),
      .ERR_O   (ERR_O)
   );

   // One register per slot, all on the shared write bus.
   // Each slot resets to the base value plus its own index.
   for (genvar i = 0; i < N_REGS; i++) begin : g_reg
      localparam logic [wbreg_pkg::DATA_W-1:0] INIT = wbreg_pkg::INIT_BASE + i;

      wb_latency_reg #(
         .INIT_VALUE    (INIT),
         .WRITE_LATENCY (WRITE_LATENCY),
         .READ_LATENCY  (READ_LATENCY)
      ) i_reg (
         .CLK_I (CLK_I),
         .rst_n (rst_n),
         .stb   (reg_stb[i]),
         .WE_I  (WE_I),
         .SEL_I (SEL_I),
         .DAT_I (DAT_I),
         .ack   (reg_ack[i]),
         .reg_q (reg_q[i])
      );
   end

   // The collector is purely combinational, so the bank adds no stage.
   wb_read_mux #(
      .N_REGS (N_REGS)
   ) i_read_mux (
      .ack_vec   (reg_ack),
      .reg_q_vec (reg_q),
      .ACK_O     (ACK_O),
      .DAT_O     (DAT_O)
   );

endmodule

`default_nettype wire

// ==== tb/tb_wb_reg_bank.sv ====
// --------------------
// Register bank testbench
// --------------------

`timescale 1ns/100ps
`default_nettype none

module tb_wb_reg_bank;

   // These match the DUT defaults, since the DUT keeps its default parameters.
   localparam int N_REGS    = 4;
   localparam int WR_LAT    = 1;
   localparam int RD_LAT    = 2;
   localparam int N_SLOTS   = 1 << wbreg_pkg::ADDR_W;
   localparam int N_WRITES  = 40;
   // Three bank readbacks, a write and read pair per random write, and a
   // write and read pair per unmapped slot.
   localparam int N_XFERS   = 3 * N_REGS + 2 * N_WRITES + 2 * (N_SLOTS - N_REGS);
   // Each transfer takes at most RD_LAT + 3 cycles. The rest is margin.
   localparam int TIMEOUT   = N_XFERS * (RD_LAT + 3) + 1400;
   // Longest wait for the response to a single transfer.
   localparam int RESP_WAIT = RD_LAT + 8;

   logic                            CLK_I;
   logic                            rst_n;
   logic [wbreg_pkg::ADDR_W-1:0]    ADR_I;
   logic [wbreg_pkg::DATA_W-1:0]    DAT_I;
   logic [wbreg_pkg::SEL_W-1:0]     SEL_I;
   logic                            WE_I;
   logic                            STB_I;
   logic [wbreg_pkg::DATA_W-1:0]    DAT_O;
   logic                            ACK_O;
   logic                            ERR_O;

   // Reference copy of every mapped register.
   logic [wbreg_pkg::DATA_W-1:0]    model [N_REGS];
   // Data that the current read must return.
   logic [wbreg_pkg::DATA_W-1:0]    exp_data;
   string                           test_name;
   int                              errors;
   int                              lost_cnt;
   int                              xfers;
   int                              cycle_cnt;
   // Consecutive cycles with STB_I low, up to the previous cycle.
   int                              low_run;
   integer                          seed;

   wb_reg_bank i_wb_reg_bank (
      .CLK_I (CLK_I),
      .rst_n (rst_n),
      .ADR_I (ADR_I),
      .DAT_I (DAT_I),
      .SEL_I (SEL_I),
      .WE_I  (WE_I),
      .STB_I (STB_I),
      .DAT_O (DAT_O),
      .ACK_O (ACK_O),
      .ERR_O (ERR_O)
   );

   // 4 ns clock period.
   initial begin
      CLK_I = 1'b0;
      forever #2 CLK_I = ~CLK_I;
   end

   always @(posedge CLK_I) begin
      if (!rst_n || STB_I) begin
         low_run <= 0;
      end else begin
         low_run <= low_run + 1;
      end
   end

   // Bus checks. All of them sample just before the edge, where the
   // inputs driven 1 ns after the previous edge are long settled.

   // Without an acknowledge the bus shows the idle pattern.
   assert property (@(posedge CLK_I) disable iff (!rst_n)
      !ACK_O |-> DAT_O == wbreg_pkg::IDLE_DATA)
   else begin
      errors++;
      $display("[FAIL] %s: idle data expected %h, actual %h",
               test_name, wbreg_pkg::IDLE_DATA, $sampled(DAT_O));
   end

   // A read acknowledge carries the value that the model holds.
   assert property (@(posedge CLK_I) disable iff (!rst_n)
      (ACK_O && !WE_I) |-> DAT_O == exp_data)
   else begin
      errors++;
      $display("[FAIL] %s: read data expected %h, actual %h",
               test_name, $sampled(exp_data), $sampled(DAT_O));
   end

   // STB_I must have risen exactly WR_LAT cycles before a write acknowledge.
   assert property (@(posedge CLK_I) disable iff (!rst_n)
      (ACK_O && WE_I) |-> ($past(STB_I, WR_LAT) && !$past(STB_I, WR_LAT + 1)))
   else begin
      errors++;
      $display("Write acknowledge was not %0d cycle(s) after the strobe rose in test %s",
               WR_LAT, test_name);
   end

   // The same for reads, with RD_LAT.
   assert property (@(posedge CLK_I) disable iff (!rst_n)
      (ACK_O && !WE_I) |-> ($past(STB_I, RD_LAT) && !$past(STB_I, RD_LAT + 1)))
   else begin
      errors++;
      $display("Read acknowledge was not %0d cycle(s) after the strobe rose in test %s",
               RD_LAT, test_name);
   end

   // The strobe is still high in the acknowledge cycle, yet the pulse ends.
   assert property (@(posedge CLK_I) disable iff (!rst_n)
      ACK_O |=> !ACK_O)
   else begin
      errors++;
      $display("Acknowledge lasted more than one cycle in test %s", test_name);
   end

   // Unmapped addresses never get an acknowledge.
   assert property (@(posedge CLK_I) disable iff (!rst_n)
      ACK_O |-> int'(ADR_I) < N_REGS)
   else begin
      errors++;
      $display("Acknowledge for unmapped address %0d in test %s",
               $sampled(ADR_I), test_name);
   end

   // An error comes in cycle 1 of a strobe to an unmapped address.
   assert property (@(posedge CLK_I) disable iff (!rst_n)
      ERR_O |-> ($past(STB_I) && !$past(STB_I, 2) && int'($past(ADR_I)) >= N_REGS))
   else begin
      errors++;
      $display("Error response outside cycle 1 of an unmapped access in test %s",
               test_name);
   end

   assert property (@(posedge CLK_I) disable iff (!rst_n)
      ERR_O |=> !ERR_O)
   else begin
      errors++;
      $display("Error response lasted more than one cycle in test %s", test_name);
   end

   assert property (@(posedge CLK_I) disable iff (!rst_n)
      !(ACK_O && ERR_O))
   else begin
      errors++;
      $display("Acknowledge and error were high together in test %s", test_name);
   end

   // A bus left idle for longer than the read latency stays quiet.
   assert property (@(posedge CLK_I) disable iff (!rst_n)
      (ACK_O || ERR_O) |-> (STB_I || low_run < RD_LAT))
   else begin
      errors++;
      $display("Response on an idle bus in test %s", test_name);
   end

   // Narrows a value to a word address.
   function automatic logic [wbreg_pkg::ADDR_W-1:0] adr_of(input logic [31:0] val);
      return val[wbreg_pkg::ADDR_W-1:0];
   endfunction

   // Builds a mask with 8 ones per selected lane and merges the new bytes in.
   function automatic logic [wbreg_pkg::DATA_W-1:0] apply_lanes(
      input logic [wbreg_pkg::DATA_W-1:0] old,
      input logic [wbreg_pkg::DATA_W-1:0] dat,
      input logic [wbreg_pkg::SEL_W-1:0]  sel
   );
      logic [wbreg_pkg::DATA_W-1:0] mask;
      mask = '0;
      for (int b = 0; b < wbreg_pkg::SEL_W; b++) begin
         mask[8*b +: 8] = {8{sel[b]}};
      end
      return (old & ~mask) | (dat & mask);
   endfunction

   // One classic cycle: raise the strobe, hold it until a response is seen
   // at an edge, then drop it for at least one cycle.
   task automatic bus_xfer(
      input logic                         we,
      input logic [wbreg_pkg::ADDR_W-1:0] adr,
      input logic [wbreg_pkg::SEL_W-1:0]  sel,
      input logic [wbreg_pkg::DATA_W-1:0] dat
   );
      int waited;
      bit got_resp;
      waited   = 0;
      got_resp = 1'b0;
      @(posedge CLK_I);
      #1;
      WE_I  = we;
      ADR_I = adr;
      SEL_I = sel;
      DAT_I = dat;
      STB_I = 1'b1;
      // Mid-cycle the outputs are settled, so look at them there.
      while (!got_resp && waited < RESP_WAIT) begin
         @(negedge CLK_I);
         if (ACK_O || ERR_O) begin
            got_resp = 1'b1;
         end else begin
            waited++;
         end
      end
      if (!got_resp) begin
         lost_cnt++;
         $display("No response to a %s at address %0d in test %s",
                  we ? "write" : "read", adr, test_name);
      end
      @(posedge CLK_I);
      #1;
      STB_I = 1'b0;
      xfers++;
   endtask

   task automatic write_reg(
      input logic [wbreg_pkg::ADDR_W-1:0] adr,
      input logic [wbreg_pkg::SEL_W-1:0]  sel,
      input logic [wbreg_pkg::DATA_W-1:0] dat
   );
      bus_xfer(1'b1, adr, sel, dat);
      if (int'(adr) < N_REGS) begin
         model[int'(adr)] = apply_lanes(model[int'(adr)], dat, sel);
      end
   endtask

   task automatic read_reg(input logic [wbreg_pkg::ADDR_W-1:0] adr);
      if (int'(adr) < N_REGS) begin
         exp_data = model[int'(adr)];
      end
      // All lanes carry the inverted expected word.
      // A store during a read then shows up in the returned data.
      bus_xfer(1'b0, adr, '1, ~exp_data);
   endtask

   // Reads every mapped register against the model.
   task automatic check_bank();
      for (int i = 0; i < N_REGS; i++) begin
         read_reg(adr_of(i));
      end
   endtask

   // Ends a run that hangs.
   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT) begin
         @(posedge CLK_I);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, the run did not finish", TIMEOUT);
      $display("tests failed");
      $finish;
   end

   initial begin : stimulus
      logic [31:0]                  rnd;
      logic [wbreg_pkg::DATA_W-1:0] dat;
      logic [wbreg_pkg::ADDR_W-1:0] adr;
      logic [wbreg_pkg::SEL_W-1:0]  sel;
      seed      = 33;
      errors    = 0;
      lost_cnt  = 0;
      xfers     = 0;
      test_name = "reset";
      exp_data  = '0;
      rst_n     = 1'b0;
      STB_I     = 1'b0;
      WE_I      = 1'b0;
      ADR_I     = '0;
      SEL_I     = '0;
      DAT_I     = '0;
      // Register i starts at the base value plus i.
      for (int i = 0; i < N_REGS; i++) begin
         model[i] = wbreg_pkg::INIT_BASE + 32'(i);
      end
      repeat (5) @(posedge CLK_I);
      #1;
      rst_n = 1'b1;

      test_name = "reset values";
      check_bank();

      // Each write is read back at once.
      // The final sweep shows that no other register was touched.
      test_name = "byte lane writes";
      for (int n = 0; n < N_WRITES; n++) begin
         rnd = $random(seed);
         adr = adr_of(rnd % N_REGS);
         rnd = $random(seed);
         sel = rnd[wbreg_pkg::SEL_W-1:0];
         dat = $random(seed);
         write_reg(adr, sel, dat);
         read_reg(adr);
      end
      check_bank();

      test_name = "unmapped addresses";
      for (int a = N_REGS; a < N_SLOTS; a++) begin
         dat = $random(seed);
         write_reg(adr_of(a), '1, dat);
         read_reg(adr_of(a));
      end
      check_bank();

      // A few idle cycles so that the quiet-bus check sees a resting bus.
      repeat (RD_LAT + 3) @(posedge CLK_I);
      // The checks at this last edge report before the counts are read.
      #1;

      $display("Summary: %0d check errors, %0d lost responses, %0d transfers",
               errors, lost_cnt, xfers);
      if (errors == 0 && lost_cnt == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/wbreg_pkg.sv
logic/wb_addr_decode.sv
logic/wb_latency_reg.sv
logic/wb_read_mux.sv
logic/wb_reg_bank.sv
tb/tb_wb_reg_bank.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the register bank testbench with Verilator.
# The run passes only if the simulation prints the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_wb_reg_bank -f verilog.f -o tb_wb_reg_bank || exit 1
sim_out=$(./obj_dir/tb_wb_reg_bank) || { echo "$sim_out"; exit 1; }
echo "$sim_out"
echo "$sim_out" | grep -qx "all tests passed" && exit 0 || exit 1
